//--- flist.f
src/proc_bus_pkg.sv
src/fetch_port_bridge.sv
src/data_port_bridge.sv
src/wb_port_arbiter.sv
src/proc_bus_top.sv
verification/tb_clock_gen.sv
verification/wb_memory_model.sv
verification/proc_bus_asserts.sv
verification/proc_bus_tb.sv

//--- verification/proc_bus_tb.sv
`default_nettype none

module proc_bus_tb
    import proc_bus_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD_NS     = 8;
    localparam int NUM_ACCESSES      = 400;
    localparam int RANDOM_ACCESSES   = 300;  // Then both ports request back to back
    localparam int CYCLES_PER_ACCESS = 20;
    localparam int IDLE_CYCLES       = 4;
    localparam int MEM_WORDS         = 256;

    logic        clk;
    logic        arst_n;
    fetch_req_t  fetch_req;
    port_rsp_t   fetch_rsp;
    data_req_t   data_req;
    port_rsp_t   data_rsp;
    wb_req_t     bus_req;
    logic        bus_stb;
    wb_rsp_t     bus_rsp;
    logic [1:0]  ack_delay;
    logic [31:0] ref_mem [MEM_WORDS];
    logic [31:0] rng_state;
    fetch_req_t  fetch_done;  // Request that took the last gnt
    data_req_t   data_done;
    logic        fetch_gnt_q;
    logic        data_gnt_q;
    logic        idle_phase;
    logic        draining;
    int          total_gnts;
    int          sat_fetch_gnts;
    int          sat_data_gnts;

    tb_clock_gen u_clock_gen (.clk_o(clk), .arst_n_o(arst_n));

    proc_bus_top dut0 (
        .sys_clk_i   (clk),
        .arst_n_i    (arst_n),
        .fetch_req_i (fetch_req),
        .fetch_rsp_o (fetch_rsp),
        .data_req_i  (data_req),
        .data_rsp_o  (data_rsp),
        .core_req_o  (bus_req),
        .core_stb_o  (bus_stb),
        .core_rsp_i  (bus_rsp)
    );

    wb_memory_model u_memory (
        .clk_i       (clk),
        .arst_n_i    (arst_n),
        .bus_req_i   (bus_req),
        .bus_stb_i   (bus_stb),
        .ack_delay_i (ack_delay),
        .bus_rsp_o   (bus_rsp)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic logic coin_flip();
        return (next_rand() & 32'h1) != 0;
    endfunction

    // Word index in the 256-word window, random low bits
    function automatic logic [31:0] random_addr();
        logic [31:0] r;
        r = next_rand();
        return {22'b0, r[9:0]};
    endfunction

    function automatic logic [31:0] lane_mask(input logic [3:0] be);
        logic [31:0] m;
        for (int i = 0; i < 4; i++) begin
            m[i*8 +: 8] = {8{be[i]}};
        end
        return m;
    endfunction

    task automatic check_val(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail %s: expected 0x%08h, got 0x%08h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic store_word(input data_req_t req);
        for (int i = 0; i < 4; i++) begin
            if (req.be[i]) begin
                ref_mem[req.addr[9:2]][i*8 +: 8] = req.wdata[i*8 +: 8];
            end
        end
    endtask

    // A port is free when idle or granted last cycle
    task automatic drive_ports(input logic may_start, input logic always_start);
        logic [31:0] r;
        if (!fetch_req.req || fetch_gnt_q) begin
            fetch_req = '0;
            if (may_start && (always_start || coin_flip())) begin
                fetch_req.req  = 1'b1;
                fetch_req.addr = random_addr();
            end
        end
        if (!data_req.req || data_gnt_q) begin
            data_req = '0;
            if (may_start && (always_start || coin_flip())) begin
                r              = next_rand();
                data_req.req   = 1'b1;
                data_req.we    = coin_flip();
                data_req.be    = r[3:0];
                data_req.addr  = random_addr();
                data_req.wdata = next_rand();
            end
        end
        r         = next_rand();
        ack_delay = r[1:0];
    endtask

    task automatic step_cycle();
        port_rsp_t f_rsp;
        port_rsp_t d_rsp;
        wb_req_t   b_req;
        logic      b_stb;
        logic      in_sat;
        int        gap;
        @(posedge clk);
        #1;
        f_rsp  = fetch_rsp;
        d_rsp  = data_rsp;
        b_req  = bus_req;
        b_stb  = bus_stb;
        in_sat = (total_gnts >= RANDOM_ACCESSES) && !draining;
        drive_ports(!idle_phase && !draining, in_sat);
        if (idle_phase) begin
            check_val("core_req_o.cyc", 0, b_req.cyc);
            check_val("core_stb_o", 0, b_stb);
            check_val("fetch_rsp_o.gnt", 0, f_rsp.gnt);
            check_val("data_rsp_o.gnt", 0, d_rsp.gnt);
        end
        check_val("fetch_rsp_o.rvalid", fetch_gnt_q, f_rsp.rvalid);
        check_val("data_rsp_o.rvalid", data_gnt_q, d_rsp.rvalid);
        if (f_rsp.rvalid) begin
            check_val("fetch_rsp_o.rdata", ref_mem[fetch_done.addr[9:2]], f_rsp.rdata);
        end
        if (d_rsp.rvalid && data_done.we) begin
            check_val("data_rsp_o.rdata", 0, d_rsp.rdata);
            store_word(data_done);
        end else if (d_rsp.rvalid) begin
            check_val("data_rsp_o.rdata",
                      ref_mem[data_done.addr[9:2]] & lane_mask(data_done.be), d_rsp.rdata);
        end
        if (!fetch_req.req) check_val("fetch_rsp_o.gnt", 0, f_rsp.gnt);
        if (!data_req.req) check_val("data_rsp_o.gnt", 0, d_rsp.gnt);
        // In the ack cycle the bus still carries the granted request
        if (f_rsp.gnt) begin
            check_val("core_req_o.we", 0, b_req.we);
            check_val("core_req_o.sel", 32'hf, b_req.sel);
            check_val("core_req_o.adr", fetch_req.addr & 32'hffff_fffc, b_req.adr);
            fetch_done = fetch_req;
            total_gnts++;
            if (in_sat) sat_fetch_gnts++;
        end
        if (d_rsp.gnt) begin
            check_val("core_req_o.we", data_req.we, b_req.we);
            check_val("core_req_o.sel", data_req.be, b_req.sel);
            check_val("core_req_o.adr", data_req.addr & 32'hffff_fffc, b_req.adr);
            if (data_req.we) begin
                check_val("core_req_o.dat", data_req.wdata, b_req.dat);
            end
            data_done = data_req;
            total_gnts++;
            if (in_sat) sat_data_gnts++;
        end
        gap = sat_fetch_gnts - sat_data_gnts;
        check_val("gnt_gap_within_one", 1, (gap <= 1) && (gap >= -1));
        fetch_gnt_q = f_rsp.gnt;
        data_gnt_q  = d_rsp.gnt;
        if (dut0.u_asserts.fail_count != 0) begin
            $display("A bus protocol assertion failed");
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    initial begin
        #(NUM_ACCESSES * CYCLES_PER_ACCESS * CLK_PERIOD_NS);
        $display("Run timed out before all accesses completed");
        $display("TEST FAILED");
        $fatal(1);
    end

    initial begin
        rng_state      = 32'hb4fca038;
        fetch_req      = '0;
        data_req       = '0;
        ack_delay      = '0;
        fetch_done     = '0;
        data_done      = '0;
        fetch_gnt_q    = 1'b0;
        data_gnt_q     = 1'b0;
        idle_phase     = 1'b1;
        draining       = 1'b0;
        total_gnts     = 0;
        sat_fetch_gnts = 0;
        sat_data_gnts  = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = 32'h9e37_79b9 * (i + 1);  // Same fill as the slave memory
        end
        @(posedge arst_n);
        repeat (IDLE_CYCLES) step_cycle();
        idle_phase = 1'b0;
        while (total_gnts < NUM_ACCESSES) step_cycle();
        draining = 1'b1;
        while (fetch_req.req || data_req.req || fetch_gnt_q || data_gnt_q) step_cycle();
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/proc_bus_asserts.sv
`default_nettype none

module proc_bus_asserts
    import proc_bus_pkg::*;
(
    input logic      sys_clk_i,
    input logic      arst_n_i,
    input wb_req_t   core_req_i,
    input logic      core_stb_i,
    input wb_rsp_t   core_rsp_i,
    input port_rsp_t fetch_rsp_i,
    input port_rsp_t data_rsp_i
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;  // Read by the testbench

    // Payload frozen until the slave acks
    bus_hold: assert property (@(posedge sys_clk_i) disable iff (!arst_n_i)
        core_req_i.cyc && !core_rsp_i.ack |=>
            $stable({core_req_i.we, core_req_i.sel, core_req_i.adr, core_req_i.dat}))
    else begin
        fail_count++;
        $error("Bus payload changed before ack");
    end

    stb_is_cyc: assert property (@(posedge sys_clk_i) disable iff (!arst_n_i)
        core_stb_i == core_req_i.cyc)
    else begin
        fail_count++;
        $error("Bus stb differs from cyc");
    end

    // The bus transaction acked to the fetch port is a read
    fetch_read_only: assert property (@(posedge sys_clk_i) disable iff (!arst_n_i)
        fetch_rsp_i.gnt |-> !core_req_i.we)
    else begin
        fail_count++;
        $error("Fetch bridge requested a write");
    end

    gnt_then_rvalid: assert property (@(posedge sys_clk_i) disable iff (!arst_n_i)
        (fetch_rsp_i.gnt |=> fetch_rsp_i.rvalid) and (data_rsp_i.gnt |=> data_rsp_i.rvalid))
    else begin
        fail_count++;
        $error("A gnt was not followed by rvalid");
    end

endmodule

bind proc_bus_top proc_bus_asserts u_asserts (
    .sys_clk_i   (sys_clk_i),
    .arst_n_i    (arst_n_i),
    .core_req_i  (core_req_o),
    .core_stb_i  (core_stb_o),
    .core_rsp_i  (core_rsp_i),
    .fetch_rsp_i (fetch_rsp_o),
    .data_rsp_i  (data_rsp_o)
);

`default_nettype wire

//--- verification/wb_memory_model.sv
`default_nettype none

module wb_memory_model
    import proc_bus_pkg::*;
(
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  wb_req_t    bus_req_i,
    input  logic       bus_stb_i,
    input  logic [1:0] ack_delay_i,  // Extra wait cycles before ack
    output wb_rsp_t    bus_rsp_o
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MEM_WORDS = 256;

    logic [BUS_DATA_W-1:0] mem [MEM_WORDS];
    logic [1:0]            wait_cnt;
    logic [7:0]            word_idx;

    assign word_idx = bus_req_i.adr[9:2];

    // Every word differs, pattern uses the whole index
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'h9e37_79b9 * (i + 1);
        end
    end

    always @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bus_rsp_o <= '0;
            wait_cnt  <= '0;
        end else if (bus_rsp_o.ack) begin
            bus_rsp_o.ack <= 1'b0;  // Single-cycle ack
            wait_cnt      <= '0;
        end else if (bus_req_i.cyc && bus_stb_i) begin
            if (wait_cnt >= ack_delay_i) begin
                bus_rsp_o.ack <= 1'b1;
                bus_rsp_o.dat <= mem[word_idx];
                for (int i = 0; i < BUS_SEL_W; i++) begin
                    if (bus_req_i.we && bus_req_i.sel[i]) begin
                        mem[word_idx][i*8 +: 8] <= bus_req_i.dat[i*8 +: 8];
                    end
                end
            end else begin
                wait_cnt <= wait_cnt + 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic arst_n_o
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD_NS = 8;
    localparam int RESET_CYCLES  = 10;

    initial begin
        clk_o = 1'b0;
        forever #(CLK_PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Release away from the edge
    initial begin
        arst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 arst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

//--- src/proc_bus_top.sv
`default_nettype none

module proc_bus_top
    import proc_bus_pkg::*;
(
    input  logic       sys_clk_i,
    input  logic       arst_n_i,

    // Core instruction port
    input  fetch_req_t fetch_req_i,
    output port_rsp_t  fetch_rsp_o,

    // Core data port
    input  data_req_t  data_req_i,
    output port_rsp_t  data_rsp_o,

    // Shared Wishbone master bus
    output wb_req_t    core_req_o,
    output logic       core_stb_o,
    input  wb_rsp_t    core_rsp_i
);

    wb_req_t fetch_wb_req;
    wb_rsp_t fetch_wb_rsp;
    wb_req_t data_wb_req;
    wb_rsp_t data_wb_rsp;

    fetch_port_bridge u_fetch_bridge (
        .sys_clk_i   (sys_clk_i),
        .arst_n_i    (arst_n_i),
        .fetch_req_i (fetch_req_i),
        .fetch_rsp_o (fetch_rsp_o),
        .wb_req_o    (fetch_wb_req),
        .wb_rsp_i    (fetch_wb_rsp)
    );

    data_port_bridge u_data_bridge (
        .sys_clk_i  (sys_clk_i),
        .arst_n_i   (arst_n_i),
        .data_req_i (data_req_i),
        .data_rsp_o (data_rsp_o),
        .wb_req_o   (data_wb_req),
        .wb_rsp_i   (data_wb_rsp)
    );

    wb_port_arbiter u_arbiter (
        .sys_clk_i      (sys_clk_i),
        .arst_n_i       (arst_n_i),
        .fetch_wb_req_i (fetch_wb_req),
        .data_wb_req_i  (data_wb_req),
        .fetch_wb_rsp_o (fetch_wb_rsp),
        .data_wb_rsp_o  (data_wb_rsp),
        .bus_req_o      (core_req_o),
        .bus_stb_o      (core_stb_o),
        .bus_rsp_i      (core_rsp_i)
    );

endmodule

`default_nettype wire

//--- src/wb_port_arbiter.sv
`default_nettype none

module wb_port_arbiter
    import proc_bus_pkg::*;
(
    input  logic    sys_clk_i,
    input  logic    arst_n_i,
    input  wb_req_t fetch_wb_req_i,
    input  wb_req_t data_wb_req_i,
    output wb_rsp_t fetch_wb_rsp_o,
    output wb_rsp_t data_wb_rsp_o,
    output wb_req_t bus_req_o,
    output logic    bus_stb_o,
    input  wb_rsp_t bus_rsp_i
);

    logic    cyc_q;       // Bus transaction open
    logic    owner_q;     // 0 fetch, 1 data
    logic    last_win_q;  // Winner of the previous arbitration
    logic    any_req;
    logic    pick_data;
    logic    fetch_owns;
    logic    data_owns;
    wb_req_t bus_q;

    assign any_req = fetch_wb_req_i.cyc || data_wb_req_i.cyc;

    // Round robin only matters when both ports ask
    always_comb begin
        if (fetch_wb_req_i.cyc && data_wb_req_i.cyc) begin
            pick_data = !last_win_q;
        end else begin
            pick_data = data_wb_req_i.cyc;
        end
    end

    always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cyc_q      <= 1'b0;
            owner_q    <= 1'b0;
            last_win_q <= 1'b1;  // Fetch wins the first tie
        end else if (cyc_q) begin
            if (bus_rsp_i.ack) begin
                cyc_q <= 1'b0;  // Idle for one cycle after ack
            end
        end else if (any_req) begin
            cyc_q      <= 1'b1;
            owner_q    <= pick_data;
            last_win_q <= pick_data;
        end
    end

    // Payload captured at arbitration and held until ack
    always_ff @(posedge sys_clk_i) begin
        if (!cyc_q && any_req) begin
            bus_q <= pick_data ? data_wb_req_i : fetch_wb_req_i;
        end
    end

    always_comb begin
        bus_req_o     = bus_q;
        bus_req_o.cyc = cyc_q;
    end

    assign bus_stb_o = cyc_q;  // No wait states from this master

    assign fetch_owns = cyc_q && !owner_q;
    assign data_owns  = cyc_q && owner_q;

    // Ack and read data go to the owner only
    always_comb begin
        fetch_wb_rsp_o.ack = bus_rsp_i.ack && fetch_owns;
        fetch_wb_rsp_o.dat = fetch_owns ? bus_rsp_i.dat : '0;
        data_wb_rsp_o.ack  = bus_rsp_i.ack && data_owns;
        data_wb_rsp_o.dat  = data_owns ? bus_rsp_i.dat : '0;
    end

endmodule

`default_nettype wire

//--- src/data_port_bridge.sv
`default_nettype none

module data_port_bridge
    import proc_bus_pkg::*;
(
    input  logic      sys_clk_i,
    input  logic      arst_n_i,
    input  data_req_t data_req_i,
    output port_rsp_t data_rsp_o,
    output wb_req_t   wb_req_o,
    input  wb_rsp_t   wb_rsp_i
);

    logic                  pending_q;  // Access granted, rvalid due
    logic [BUS_DATA_W-1:0] rdata_q;
    logic [BUS_DATA_W-1:0] lane_mask;
    logic [BUS_DATA_W-1:0] load_data;

    // Loads and stores share one word-aligned request
    always_comb begin
        wb_req_o.cyc = data_req_i.req && !pending_q;
        wb_req_o.we  = data_req_i.we;
        wb_req_o.sel = data_req_i.be;
        wb_req_o.adr = {data_req_i.addr[BUS_ADDR_W-1:2], 2'b00};
        wb_req_o.dat = data_req_i.wdata;
    end

    // Expand be into a bit mask, one byte per lane
    always_comb begin
        for (int i = 0; i < BUS_SEL_W; i++) begin
            lane_mask[i*8 +: 8] = {8{data_req_i.be[i]}};
        end
    end

    // Unselected lanes read as zero, stores return zero
    assign load_data = data_req_i.we ? '0 : (wb_rsp_i.dat & lane_mask);

    always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pending_q <= 1'b0;
        end else begin
            pending_q <= wb_rsp_i.ack;  // Blocks the cycle after gnt
        end
    end

    // be and we are still held by the core in the ack cycle
    always_ff @(posedge sys_clk_i) begin
        if (wb_rsp_i.ack) begin
            rdata_q <= load_data;
        end
    end

    always_comb begin
        data_rsp_o.gnt    = wb_rsp_i.ack;
        data_rsp_o.rvalid = pending_q;
        data_rsp_o.rdata  = rdata_q;
    end

endmodule

`default_nettype wire

//--- src/fetch_port_bridge.sv
`default_nettype none

module fetch_port_bridge
    import proc_bus_pkg::*;
(
    input  logic       sys_clk_i,
    input  logic       arst_n_i,
    input  fetch_req_t fetch_req_i,
    output port_rsp_t  fetch_rsp_o,
    output wb_req_t    wb_req_o,
    input  wb_rsp_t    wb_rsp_i
);

    // Set in the cycle after gnt, which is also the rvalid cycle
    logic                  pending_q;
    logic [BUS_DATA_W-1:0] rdata_q;

    // Fetches are always full-word reads
    always_comb begin
        wb_req_o.cyc = fetch_req_i.req && !pending_q; // No re-issue of a granted fetch
        wb_req_o.we  = 1'b0;
        wb_req_o.sel = '1;
        wb_req_o.adr = {fetch_req_i.addr[BUS_ADDR_W-1:2], 2'b00};
        wb_req_o.dat = '0;
    end

    // Core moves on to its next request right after gnt
    always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pending_q <= 1'b0;
        end else begin
            pending_q <= wb_rsp_i.ack;
        end
    end

    // Read data held for the rvalid cycle
    always_ff @(posedge sys_clk_i) begin
        if (wb_rsp_i.ack) begin
            rdata_q <= wb_rsp_i.dat;
        end
    end

    // gnt in the ack cycle, rvalid one cycle later
    always_comb begin
        fetch_rsp_o.gnt    = wb_rsp_i.ack;
        fetch_rsp_o.rvalid = pending_q;
        fetch_rsp_o.rdata  = rdata_q;
    end

endmodule

`default_nettype wire

//--- src/proc_bus_pkg.sv
`default_nettype none

package proc_bus_pkg;

    // Bus widths
    localparam int BUS_ADDR_W = 32;
    localparam int BUS_DATA_W = 32;
    localparam int BUS_SEL_W  = 4;  // One select per byte lane

    // Instruction fetch port, core to bridge
    typedef struct packed {
        logic                  req;
        logic [BUS_ADDR_W-1:0] addr;
    } fetch_req_t;

    // Data port, core to bridge
    typedef struct packed {
        logic                  req;
        logic                  we;    // 1 = store
        logic [BUS_SEL_W-1:0]  be;
        logic [BUS_ADDR_W-1:0] addr;
        logic [BUS_DATA_W-1:0] wdata;
    } data_req_t;

    // Response to either core port
    typedef struct packed {
        logic                  gnt;
        logic                  rvalid;
        logic [BUS_DATA_W-1:0] rdata;
    } port_rsp_t;

    // Wishbone request, bridge side and bus side
    typedef struct packed {
        logic                  cyc;
        logic                  we;
        logic [BUS_SEL_W-1:0]  sel;
        logic [BUS_ADDR_W-1:0] adr;
        logic [BUS_DATA_W-1:0] dat;
    } wb_req_t;

    // Wishbone response from the slave
    typedef struct packed {
        logic                  ack;
        logic [BUS_DATA_W-1:0] dat;
    } wb_rsp_t;

endpackage

`default_nettype wire
